//--- hw/vic_pkg.sv
package vic_pkg;

  // cpu access opcode, one per ce falling edge
  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2
  } reg_op_e;

  // register offsets within the 64-byte window
  typedef enum logic [5:0] {
    reg_ctrl       = 6'h11,  // bit 4 display enable, bit 7 compare msb
    reg_raster     = 6'h12,  // wr compare low byte, rd current line
    reg_irq_status = 6'h19,  // write 1 to clear
    reg_irq_enable = 6'h1a,
    reg_border     = 6'h20,
    reg_background = 6'h21
  } reg_addr_e;

  typedef struct packed {
    reg_op_e    op;
    reg_addr_e  addr;
    logic [7:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [8:0] h;  // dot within line
    logic [8:0] v;  // line within frame
  } raster_pos_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // raster geometry, sync and blank both start at position 0
  localparam logic [8:0] h_sync_len = 9'd4;
  localparam logic [8:0] v_sync_len = 9'd2;
  localparam logic [8:0] h_blank    = 9'd8;
  localparam logic [8:0] v_blank    = 9'd4;
  localparam logic [8:0] border_w   = 9'd4;  // border band, pixels and lines

  // the usual 16 colours, cut down to 4 bits per gun
  localparam rgb_t palette [16] = '{
    '{4'h0, 4'h0, 4'h0},  // black
    '{4'hf, 4'hf, 4'hf},  // white
    '{4'h8, 4'h3, 4'h3},  // red
    '{4'h6, 4'hb, 4'hb},  // cyan
    '{4'h8, 4'h4, 4'h9},  // purple
    '{4'h5, 4'ha, 4'h4},  // green
    '{4'h4, 4'h3, 4'h8},  // blue
    '{4'hb, 4'hc, 4'h7},  // yellow
    '{4'h8, 4'h5, 4'h2},  // orange
    '{4'h5, 4'h4, 4'h0},  // brown
    '{4'hb, 4'h6, 4'h6},  // light red
    '{4'h5, 4'h5, 4'h5},  // dark grey
    '{4'h7, 4'h7, 4'h7},  // mid grey
    '{4'h9, 4'he, 4'h8},  // light green
    '{4'h7, 4'h6, 4'hc},  // light blue
    '{4'h9, 4'h9, 4'h9}   // light grey
  };

endpackage : vic_pkg

//--- hw/vic_reg_decode.sv
`timescale 1ns/1ns

module vic_reg_decode (
  input  logic              clk_dot4x,
  input  logic              rst_n,
  input  logic              ce,     // chip enable, low = selected
  input  logic              rw,     // high = cpu read
  input  logic [5:0]        adi,    // register offset
  input  logic [7:0]        dbi,    // write data
  output vic_pkg::reg_req_t req
);
  import vic_pkg::*;

  logic    ce_q;       // ce as sampled on the previous edge
  logic    ce_fall;
  logic    mapped;     // adi hits a real register
  reg_op_e op_d;
  reg_op_e op_q;
  logic [5:0] addr_q;
  logic [7:0] wdata_q;

  assign ce_fall = ce_q & ~ce;

  always_comb begin
    case (adi)
      reg_ctrl, reg_raster, reg_irq_status,
      reg_irq_enable, reg_border, reg_background: mapped = 1'b1;
      default:                                    mapped = 1'b0;
    endcase
  end

  // reads always go through, so unmapped offsets can answer 0xff
  always_comb begin
    op_d = op_none;
    if (ce_fall) begin
      if (rw)          op_d = op_read;
      else if (mapped) op_d = op_write;  // stray writes vanish here
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      ce_q <= 1'b0;  // no access until ce has been seen high
      op_q <= op_none;
    end else begin
      ce_q <= ce;
      op_q <= op_d;
    end
  end

  always_ff @(posedge clk_dot4x) begin
    addr_q  <= adi;  // captured with the strobe
    wdata_q <= dbi;
  end

  assign req = '{op: op_q, addr: reg_addr_e'(addr_q), wdata: wdata_q};

  // ce must go high again between accesses
  a_no_back_to_back_write: assert property (
    @(posedge clk_dot4x) disable iff (!rst_n)
    req.op == op_write |=> req.op != op_write
  );

endmodule : vic_reg_decode

//--- hw/vic_reg_file.sv
`timescale 1ns/1ns

module vic_reg_file (
  input  logic                 clk_dot4x,
  input  logic                 rst_n,
  input  vic_pkg::reg_req_t    req,            // one-cycle access strobe
  input  vic_pkg::raster_pos_t pos,            // live beam position
  input  logic                 raster_hit,     // compare line reached
  output logic [7:0]           dbo,            // read data to cpu
  output logic                 vic_write_db,   // dbo valid, drive bus
  output logic                 irq,            // active low
  output logic [8:0]           raster_cmp,
  output logic [3:0]           border_idx,
  output logic [3:0]           background_idx,
  output logic                 display_en
);
  import vic_pkg::*;

  logic [7:0] ctrl_q;        // bit 7 doubles as compare msb
  logic [7:0] raster_lo_q;   // compare low byte
  logic [3:0] irq_status_q;  // bit 0 raster, rest unused here
  logic [3:0] irq_enable_q;
  logic [3:0] border_q;
  logic [3:0] background_q;
  logic       irq_pend;      // any enabled source set
  logic       wr;
  logic       rd;
  logic [7:0] rdata;
  logic [3:0] status_d;

  assign wr = (req.op == op_write);
  assign rd = (req.op == op_read);

  assign irq_pend = |(irq_status_q & irq_enable_q);
  assign irq      = ~irq_pend;

  assign raster_cmp     = {ctrl_q[7], raster_lo_q};
  assign display_en     = ctrl_q[4];
  assign border_idx     = border_q;
  assign background_idx = background_q;

  // write 1 clears; a hit on the same edge keeps the bit set
  always_comb begin
    status_d = irq_status_q;
    if (wr && req.addr == reg_irq_status)
      status_d = irq_status_q & ~req.wdata[3:0];
    if (raster_hit)
      status_d[0] = 1'b1;
  end

  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      ctrl_q       <= 8'h00;
      raster_lo_q  <= 8'h00;
      irq_status_q <= 4'h0;
      irq_enable_q <= 4'h0;
      border_q     <= 4'h0;
      background_q <= 4'h0;
    end else begin
      irq_status_q <= status_d;
      if (wr) begin
        case (req.addr)
          reg_ctrl:       ctrl_q       <= req.wdata;
          reg_raster:     raster_lo_q  <= req.wdata;
          reg_irq_enable: irq_enable_q <= req.wdata[3:0];
          reg_border:     border_q     <= req.wdata[3:0];
          reg_background: background_q <= req.wdata[3:0];
          default:        ;  // status handled above
        endcase
      end
    end
  end

  // read mux, unused bits float high like the real part
  always_comb begin
    case (req.addr)
      reg_ctrl:       rdata = ctrl_q;
      reg_raster:     rdata = pos.v[7:0];                     // line at request time
      reg_irq_status: rdata = {irq_pend, 3'b111, irq_status_q};
      reg_irq_enable: rdata = {4'hf, irq_enable_q};
      reg_border:     rdata = {4'hf, border_q};
      reg_background: rdata = {4'hf, background_q};
      default:        rdata = 8'hff;                          // unmapped
    endcase
  end

  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) vic_write_db <= 1'b0;
    else        vic_write_db <= rd;
  end

  always_ff @(posedge clk_dot4x) begin
    if (rd) dbo <= rdata;  // held until the next read
  end

  // decode only ever strobes once per ce cycle
  a_write_db_single: assert property (
    @(posedge clk_dot4x) disable iff (!rst_n)
    vic_write_db |=> !vic_write_db
  );

endmodule : vic_reg_file

//--- hw/vic_raster.sv
`timescale 1ns/1ns

module vic_raster #(
  parameter logic [8:0] h_total = 9'd64,  // dots per line
  parameter logic [8:0] v_total = 9'd40   // lines per frame
) (
  input  logic                 clk_dot4x,
  input  logic                 rst_n,
  input  logic [8:0]           raster_cmp,  // interrupt line
  output vic_pkg::raster_pos_t pos,
  output logic                 hsync_raw,
  output logic                 vsync_raw,
  output logic                 active_raw,
  output logic                 raster_hit
);
  import vic_pkg::*;

  localparam logic [8:0] h_last = h_total - 9'd1;
  localparam logic [8:0] v_last = v_total - 9'd1;

  logic [8:0] h_q;
  logic [8:0] v_q;
  logic       h_wrap;  // last dot of the line

  assign h_wrap = (h_q == h_last);

  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      h_q <= 9'd0;
      v_q <= 9'd0;
    end else begin
      if (h_wrap) begin
        h_q <= 9'd0;
        if (v_q == v_last) v_q <= 9'd0;  // new frame
        else               v_q <= v_q + 9'd1;
      end else begin
        h_q <= h_q + 9'd1;
      end
    end
  end

  assign pos = '{h: h_q, v: v_q};

  // sync pulses sit at the start of blanking
  assign hsync_raw  = (h_q < h_sync_len);
  assign vsync_raw  = (v_q < v_sync_len);
  assign active_raw = (h_q >= h_blank) && (v_q >= v_blank);

  // one cycle per frame, at the first dot of the compare line
  assign raster_hit = (h_q == 9'd0) && (v_q == raster_cmp);

  a_pos_in_range: assert property (
    @(posedge clk_dot4x) disable iff (!rst_n)
    (pos.h < h_total) && (pos.v < v_total)
  );

endmodule : vic_raster

//--- hw/vic_pixel_out.sv
`timescale 1ns/1ns

module vic_pixel_out #(
  parameter logic [8:0] h_total = 9'd64,
  parameter logic [8:0] v_total = 9'd40
) (
  input  logic                 clk_dot4x,
  input  logic                 rst_n,
  input  vic_pkg::raster_pos_t pos,
  input  logic                 hsync_raw,
  input  logic                 vsync_raw,
  input  logic                 active_raw,
  input  logic                 display_en,
  input  logic [3:0]           border_idx,
  input  logic [3:0]           background_idx,
  output logic                 hsync,
  output logic                 vsync,
  output logic                 active,
  output vic_pkg::rgb_t        rgb
);
  import vic_pkg::*;

  // inner window, border_w in from each edge of the active area
  localparam logic [8:0] h_win_lo = h_blank + border_w;
  localparam logic [8:0] h_win_hi = h_total - border_w;
  localparam logic [8:0] v_win_lo = v_blank + border_w;
  localparam logic [8:0] v_win_hi = v_total - border_w;

  logic       in_win;
  logic [3:0] col_idx;
  rgb_t       rgb_d;

  assign in_win = (pos.h >= h_win_lo) && (pos.h < h_win_hi) &&
                  (pos.v >= v_win_lo) && (pos.v < v_win_hi);

  assign col_idx = (display_en && in_win) ? background_idx : border_idx;
  assign rgb_d   = active_raw ? palette[col_idx] : '0;  // black in blanking

  // one stage, sync and colour stay aligned
  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      active <= 1'b0;
      rgb    <= '0;
    end else begin
      hsync  <= hsync_raw;
      vsync  <= vsync_raw;
      active <= active_raw;
      rgb    <= rgb_d;
    end
  end

  a_blank_is_black: assert property (
    @(posedge clk_dot4x) disable iff (!rst_n)
    !active |-> rgb == '0
  );

endmodule : vic_pixel_out

//--- hw/vic_top.sv
`timescale 1ns/1ns

module vic_top #(
  parameter logic [8:0] h_total = 9'd64,
  parameter logic [8:0] v_total = 9'd40
) (
  input  logic       clk_dot4x,
  input  logic       rst_n,
  input  logic       ce,            // active low select
  input  logic       rw,            // high = read
  input  logic [5:0] adi,
  input  logic [7:0] dbi,
  output logic [7:0] dbo,
  output logic       vic_write_db,  // cpu read data valid
  output logic       irq,           // active low
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);
  import vic_pkg::*;

  reg_req_t    req;
  raster_pos_t pos;
  logic        raster_hit;
  logic [8:0]  raster_cmp;
  logic [3:0]  border_idx;
  logic [3:0]  background_idx;
  logic        display_en;
  logic        hsync_raw;
  logic        vsync_raw;
  logic        active_raw;
  rgb_t        rgb;

  vic_reg_decode vic_reg_decode_i (
    .clk_dot4x (clk_dot4x),
    .rst_n     (rst_n),
    .ce        (ce),
    .rw        (rw),
    .adi       (adi),
    .dbi       (dbi),
    .req       (req)
  );

  vic_reg_file vic_reg_file_i (
    .clk_dot4x      (clk_dot4x),
    .rst_n          (rst_n),
    .req            (req),
    .pos            (pos),
    .raster_hit     (raster_hit),
    .dbo            (dbo),
    .vic_write_db   (vic_write_db),
    .irq            (irq),
    .raster_cmp     (raster_cmp),
    .border_idx     (border_idx),
    .background_idx (background_idx),
    .display_en     (display_en)
  );

  vic_raster #(.h_total(h_total), .v_total(v_total)) vic_raster_i (
    .clk_dot4x  (clk_dot4x),
    .rst_n      (rst_n),
    .raster_cmp (raster_cmp),
    .pos        (pos),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .active_raw (active_raw),
    .raster_hit (raster_hit)
  );

  vic_pixel_out #(.h_total(h_total), .v_total(v_total)) vic_pixel_out_i (
    .clk_dot4x      (clk_dot4x),
    .rst_n          (rst_n),
    .pos            (pos),
    .hsync_raw      (hsync_raw),
    .vsync_raw      (vsync_raw),
    .active_raw     (active_raw),
    .display_en     (display_en),
    .border_idx     (border_idx),
    .background_idx (background_idx),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .rgb            (rgb)
  );

  // guns to pins
  assign red   = rgb.red;
  assign green = rgb.green;
  assign blue  = rgb.blue;

endmodule : vic_top

//--- dv/vic_tb.sv
`timescale 1ns/1ns

module vic_tb;
  import vic_pkg::*;

  localparam logic [8:0] h_total = 9'd64;
  localparam logic [8:0] v_total = 9'd40;
  localparam int frame_len = int'(h_total) * int'(v_total);
  localparam int n_access = 64;  // upper bound on cpu accesses below
  localparam int cycle_limit = 3 * frame_len + 20 * n_access;

  // colour table, one 12-bit rgb per index
  localparam rgb_t pal_m [16] = '{
    12'h000, 12'hfff, 12'h833, 12'h6bb, 12'h849, 12'h5a4, 12'h438, 12'hbc7,
    12'h852, 12'h540, 12'hb66, 12'h555, 12'h777, 12'h9e8, 12'h76c, 12'h999
  };
  localparam logic [5:0] map_tbl [6] = '{6'h11, 6'h12, 6'h19, 6'h1a, 6'h20, 6'h21};

  logic clk_dot4x = 1'b0;
  logic rst_n;
  logic ce, rw;
  logic [5:0] adi;
  logic [7:0] dbi;
  logic [7:0] dbo;
  logic vic_write_db, irq, hsync, vsync, active;
  logic [3:0] red, green, blue;
  rgb_t dut_rgb;

  integer seed = 32'h333e_85c9;
  integer cycles = 0;
  logic chk_on = 1'b0;  // per-cycle compare enable

  // reference model state
  logic m_ce_q, m_hit, m_status, m_wdb;
  reg_op_e m_op;
  logic [5:0] m_addr;
  logic [7:0] m_wdata, m_ctrl, m_cmp_lo, m_dbo;
  logic [3:0] m_enable, m_border, m_bg;
  logic [8:0] m_h, m_v;
  logic [2:0] m_sync;  // hsync, vsync, active
  rgb_t m_rgb;

  vic_top #(.h_total(h_total), .v_total(v_total)) vic_top_i (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
    .dbo(dbo), .vic_write_db(vic_write_db), .irq(irq), .hsync(hsync), .vsync(vsync),
    .active(active), .red(red), .green(green), .blue(blue)
  );

  assign dut_rgb = {red, green, blue};

  always #50 clk_dot4x = ~clk_dot4x;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic byte_match(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic rgb_match(input rgb_t got, input rgb_t exp);
    if (got !== exp)
      abort_run($sformatf("Error: rgb = 0x%h, expected 0x%h", got, exp));
  endtask

  task automatic sync_match(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
      abort_run($sformatf("Error: {hsync,vsync,active} = 0x%h, expected 0x%h", got, exp));
  endtask

  task automatic bit_match(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic logic mapped_addr(input logic [5:0] a);
    return (a == 6'h11) || (a == 6'h12) || (a == 6'h19) ||
           (a == 6'h1a) || (a == 6'h20) || (a == 6'h21);
  endfunction

  function automatic logic [7:0] model_rdata(input logic [5:0] a);
    logic pend;
    pend = m_status & m_enable[0];
    case (a)
      reg_ctrl:       return m_ctrl;
      reg_raster:     return m_v[7:0];  // line at request time
      reg_irq_status: return {pend, 6'b111_000, m_status};
      reg_irq_enable: return {4'hf, m_enable};
      reg_border:     return {4'hf, m_border};
      reg_background: return {4'hf, m_bg};
      default:        return 8'hff;
    endcase
  endfunction

  function automatic rgb_t expected_rgb(input logic [8:0] h, input logic [8:0] v);
    logic inner;
    if (h < h_blank || v < v_blank) return '0;  // blanking
    inner = (h >= h_blank + border_w) && (h < h_total - border_w) &&
            (v >= v_blank + border_w) && (v < v_total - border_w);
    return (m_ctrl[4] && inner) ? pal_m[m_bg] : pal_m[m_border];
  endfunction

  // cycle model, samples tb inputs which only move on the falling edge
  always @(posedge clk_dot4x) begin
    m_hit = (m_h == 9'd0) && (m_v == {m_ctrl[7], m_cmp_lo});
    if (!rst_n) begin
      m_ce_q <= 1'b0;
      m_op <= op_none;
      {m_h, m_v, m_ctrl, m_cmp_lo} <= '0;
      {m_status, m_enable, m_border, m_bg} <= '0;
      m_wdb <= 1'b0;
      m_sync <= 3'b000;
      m_rgb <= '0;
    end else begin
      m_ce_q <= ce;
      m_addr <= adi;
      m_wdata <= dbi;
      if (m_ce_q && !ce && rw) m_op <= op_read;
      else if (m_ce_q && !ce && mapped_addr(adi)) m_op <= op_write;  // stray writes dropped
      else m_op <= op_none;
      m_h <= (m_h == h_total - 9'd1) ? 9'd0 : m_h + 9'd1;
      if (m_h == h_total - 9'd1) m_v <= (m_v == v_total - 9'd1) ? 9'd0 : m_v + 9'd1;
      if (m_op == op_write) begin
        case (m_addr)
          reg_ctrl:       m_ctrl <= m_wdata;
          reg_raster:     m_cmp_lo <= m_wdata;
          reg_irq_status: if (m_wdata[0]) m_status <= 1'b0;
          reg_irq_enable: m_enable <= m_wdata[3:0];
          reg_border:     m_border <= m_wdata[3:0];
          reg_background: m_bg <= m_wdata[3:0];
          default:        ;
        endcase
      end
      if (m_hit) m_status <= 1'b1;  // hit beats a same-edge clear
      m_wdb <= (m_op == op_read);
      if (m_op == op_read) m_dbo <= model_rdata(m_addr);
      m_sync <= {m_h < h_sync_len, m_v < v_sync_len, (m_h >= h_blank) && (m_v >= v_blank)};
      m_rgb <= expected_rgb(m_h, m_v);
    end
  end

  // outputs only move on the rising edge, compare in the middle of the cycle
  always @(negedge clk_dot4x) begin
    if (chk_on) begin
      sync_match({hsync, vsync, active}, m_sync);
      rgb_match(dut_rgb, m_rgb);
      bit_match("irq", irq, ~(m_status & m_enable[0]));
      bit_match("vic_write_db", vic_write_db, m_wdb);
      if (m_wdb) byte_match("dbo", dbo, m_dbo);
    end
  end

  always @(posedge clk_dot4x) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
      abort_run($sformatf("timeout, run went past %0d cycles", cycle_limit));
  end

  task automatic write_reg(input logic [5:0] a, input logic [7:0] d);
    @(negedge clk_dot4x);
    {ce, rw, adi, dbi} = {1'b0, 1'b0, a, d};
    repeat (2) @(negedge clk_dot4x);  // past E1, write has landed
    ce = 1'b1;
    @(negedge clk_dot4x);
  endtask

  task automatic read_reg(input logic [5:0] a);
    int n;
    @(negedge clk_dot4x);
    {ce, rw, adi} = {1'b0, 1'b1, a};
    n = 0;
    do begin
      @(negedge clk_dot4x);
      n++;
    end while (vic_write_db !== 1'b1 && n < 4);
    if (vic_write_db !== 1'b1)
      abort_run($sformatf("no vic_write_db pulse for read of address 0x%h", a));
    ce = 1'b1;  // dbo itself is compared by the cycle check
    @(negedge clk_dot4x);
  endtask

  initial begin
    logic [31:0] rnd;
    int n;
    {ce, rw, adi, dbi} = {1'b1, 1'b1, 6'h00, 8'h00};
    rst_n = 1'b0;
    repeat (2) @(negedge clk_dot4x);
    rst_n = 1'b1;
    bit_match("irq", irq, 1'b1);
    bit_match("vic_write_db", vic_write_db, 1'b0);
    sync_match({hsync, vsync, active}, 3'b000);
    rgb_match(dut_rgb, '0);
    chk_on = 1'b1;

    repeat (40) begin  // mixed traffic, about half to unmapped offsets
      rnd = $random(seed);
      adi = rnd[8] ? rnd[5:0] : map_tbl[rnd[11:9] % 3'd6];
      if (rnd[12]) read_reg(adi);
      else write_reg(adi, rnd[23:16]);
    end

    // read back every mapped register after the random writes
    for (int i = 0; i < 6; i++) begin
      read_reg(map_tbl[i]);
    end

    for (int i = 0; i < 2; i++) begin  // display off, then on
      rnd = $random(seed);
      write_reg(reg_border, rnd[7:0]);
      write_reg(reg_background, rnd[15:8]);
      write_reg(reg_ctrl, (i == 1) ? 8'h10 : 8'h00);
      repeat (frame_len) @(negedge clk_dot4x);
    end

    rnd = $random(seed);
    write_reg(reg_raster, rnd[7:0] % 8'd40);
    write_reg(reg_ctrl, 8'h10);  // compare msb 0
    write_reg(reg_irq_status, 8'h01);
    write_reg(reg_irq_enable, 8'h01);
    n = 0;
    while (irq !== 1'b0 && n < frame_len + 8) begin
      @(negedge clk_dot4x);
      n++;
    end
    if (irq !== 1'b0) abort_run("irq never fell for the raster compare line");
    read_reg(reg_irq_status);
    write_reg(reg_irq_status, 8'h01);
    bit_match("irq", irq, 1'b1);
    read_reg(reg_irq_status);

    repeat (4) begin
      rnd = $random(seed);
      repeat (rnd[5:0]) @(negedge clk_dot4x);
      read_reg(reg_raster);
    end

    repeat (4) @(negedge clk_dot4x);
    $display("TEST OK");
    $finish;
  end

endmodule : vic_tb

//--- vlog.f
hw/vic_pkg.sv
hw/vic_reg_decode.sv
hw/vic_reg_file.sv
hw/vic_raster.sv
hw/vic_pixel_out.sv
hw/vic_top.sv
dv/vic_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module vic_tb -f vlog.f \
  -o vic_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/vic_sim > sim.log 2>&1 ; cat sim.log

! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log && exit 0
echo "simulation failed"
exit 1
